// File: src/lsu_consts.svh
//**************************************************************************
// Load/store unit constants
// Data cache geometry, physical address width and host I/O location
//**************************************************************************

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Cache line geometry
`define LSU_LINE_BYTES 8
`define LSU_OFFSET_WIDTH 3
`define LSU_INDEX_WIDTH 4
`define LSU_LINE_COUNT (1 << `LSU_INDEX_WIDTH)

// Physical addressing
`define LSU_ADDR_WIDTH 16
`define LSU_TAG_WIDTH (`LSU_ADDR_WIDTH - `LSU_INDEX_WIDTH - `LSU_OFFSET_WIDTH)
`define LSU_WORD_WIDTH 32

// Last word of memory
`define LSU_HOST_IO_ADDR 16'hfffc

`endif

// File: src/memTypesPkg.sv
//**************************************************************************
// Memory types
// Vector types for addresses, cache fields, lines, byte masks and words
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

package memTypesPkg;

    // Byte address and line address
    typedef logic [`LSU_ADDR_WIDTH-1:0] addrT;
    typedef logic [`LSU_ADDR_WIDTH-`LSU_OFFSET_WIDTH-1:0] lineAddrT;

    // Cache fields
    typedef logic [`LSU_TAG_WIDTH-1:0] tagT;
    typedef logic [`LSU_INDEX_WIDTH-1:0] indexT;

    // Data
    typedef logic [`LSU_LINE_BYTES*8-1:0] lineT;
    typedef logic [`LSU_LINE_BYTES-1:0] byteMaskT;
    typedef logic [`LSU_WORD_WIDTH-1:0] wordT;

endpackage

`default_nettype wire

// File: src/opTypesPkg.sv
//**************************************************************************
// Operation types
// Requester commands, access sizes, atomic operations and FSM states
//**************************************************************************

`default_nettype none

package opTypesPkg;

    typedef enum logic [1:0] {
        commandNone = 2'd0,
        commandLoad = 2'd1,
        commandStore = 2'd2,
        commandAtomic = 2'd3
    } lsuCommandT;

    typedef enum logic [2:0] {
        sizeWord = 3'd0,
        sizeHalf = 3'd1,
        sizeHalfUnsigned = 3'd2,
        sizeByte = 3'd3,
        sizeByteUnsigned = 3'd4
    } accessSizeT;

    typedef enum logic [3:0] {
        atomicSwap = 4'd0,
        atomicAdd = 4'd1,
        atomicXor = 4'd2,
        atomicAnd = 4'd3,
        atomicOr = 4'd4,
        atomicMin = 4'd5,
        atomicMax = 4'd6,
        atomicMinu = 4'd7,
        atomicMaxu = 4'd8
    } atomicOpT;

    typedef enum logic [2:0] {
        stateIdle = 3'd0,
        stateLookup = 3'd1,
        stateStore = 3'd2,
        stateRefill = 3'd3,
        stateWriteThrough = 3'd4
    } controlStateT;

endpackage

`default_nettype wire

// File: src/tagArray.sv
//**************************************************************************
// Tag array
// Valid bits and tags of the direct-mapped data cache, registered read
// and hit detection against the tag of the previous lookup address
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

module tagArray (
    input  logic clk,
    input  logic rst,
    input  memTypesPkg::addrT lookupAddr,
    input  logic refillEnable,
    output logic hit
);
    logic [`LSU_LINE_COUNT-1:0] valid;
    memTypesPkg::tagT tags [`LSU_LINE_COUNT];

    memTypesPkg::indexT index;
    memTypesPkg::tagT lookupTag;
    memTypesPkg::tagT heldTag;
    memTypesPkg::tagT readTag;
    logic readValid;

    assign index = lookupAddr[`LSU_OFFSET_WIDTH +: `LSU_INDEX_WIDTH];
    assign lookupTag = lookupAddr[`LSU_ADDR_WIDTH-1 -: `LSU_TAG_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            readValid <= 1'b0;
        end else begin
            if (refillEnable) begin
                valid[index] <= 1'b1;
            end
            // Refill shows up on the next read
            readValid <= valid[index] | refillEnable;
        end
    end

    always_ff @(posedge clk) begin
        if (refillEnable) begin
            tags[index] <= lookupTag;
        end
        readTag <= refillEnable ? lookupTag : tags[index];
        heldTag <= lookupTag;
    end

    assign hit = readValid && (readTag == heldTag);

    // A refill is always followed by a return to idle
    noBackToBackRefill: assert property (@(posedge clk) disable iff (rst)
        refillEnable |=> !refillEnable);

endmodule

`default_nettype wire

// File: src/dataArray.sv
//**************************************************************************
// Data array
// Byte-banked cache line storage with registered read, word extraction
// with sign or zero extension, and byte-masked store merge
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

module dataArray (
    input  logic clk,
    input  memTypesPkg::addrT lookupAddr,
    input  opTypesPkg::accessSizeT accessSize,
    input  logic refillEnable,
    input  memTypesPkg::lineT refillLine,
    input  logic storeEnable,
    input  memTypesPkg::wordT storeWord,
    output memTypesPkg::wordT loadWord,
    output memTypesPkg::lineT lineValue
);
    logic [7:0] banks [`LSU_LINE_BYTES][`LSU_LINE_COUNT];

    memTypesPkg::indexT index;
    logic [`LSU_OFFSET_WIDTH-1:0] offset;
    logic [`LSU_OFFSET_WIDTH-1:0] readOffset;
    memTypesPkg::byteMaskT writeMask;
    memTypesPkg::lineT writeLine;
    memTypesPkg::lineT readLine;
    memTypesPkg::wordT shiftedWord;

    function automatic memTypesPkg::byteMaskT sizeMask(opTypesPkg::accessSizeT size);
        case (size)
            opTypesPkg::sizeWord: return 8'b0000_1111;
            opTypesPkg::sizeHalf, opTypesPkg::sizeHalfUnsigned: return 8'b0000_0011;
            default: return 8'b0000_0001;
        endcase
    endfunction

    function automatic memTypesPkg::wordT extend(
        memTypesPkg::wordT value,
        opTypesPkg::accessSizeT size
    );
        case (size)
            opTypesPkg::sizeHalf: return {{16{value[15]}}, value[15:0]};
            opTypesPkg::sizeHalfUnsigned: return {16'h0000, value[15:0]};
            opTypesPkg::sizeByte: return {{24{value[7]}}, value[7:0]};
            opTypesPkg::sizeByteUnsigned: return {24'h000000, value[7:0]};
            default: return value;
        endcase
    endfunction

    assign index = lookupAddr[`LSU_OFFSET_WIDTH +: `LSU_INDEX_WIDTH];
    assign offset = lookupAddr[`LSU_OFFSET_WIDTH-1:0];

    // Refill replaces the whole line
    always_comb begin
        if (refillEnable) begin
            writeMask = '1;
            writeLine = refillLine;
        end else if (storeEnable) begin
            writeMask = sizeMask(accessSize) << offset;
            writeLine = memTypesPkg::lineT'(storeWord) << {offset, 3'b000};
        end else begin
            writeMask = '0;
            writeLine = '0;
        end
    end

    always_ff @(posedge clk) begin
        readOffset <= offset;
        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            if (writeMask[b]) begin
                banks[b][index] <= writeLine[8*b +: 8];
                readLine[8*b +: 8] <= writeLine[8*b +: 8];
            end else begin
                readLine[8*b +: 8] <= banks[b][index];
            end
        end
    end

    assign shiftedWord = memTypesPkg::wordT'(readLine >> {readOffset, 3'b000});
    assign loadWord = extend(shiftedWord, accessSize);
    assign lineValue = readLine;

    // Refill and store come from different controller states
    storeRefillExclusive: assert property (@(posedge clk)
        !(storeEnable && refillEnable));

endmodule

`default_nettype wire

// File: src/loadStoreControl.sv
//**************************************************************************
// Load/store controller
// Request FSM, atomic ALU, refill and write-through sequencing on the
// line-wide memory port, and the host I/O register
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

module loadStoreControl (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  opTypesPkg::lsuCommandT command,
    input  memTypesPkg::addrT addr,
    input  opTypesPkg::accessSizeT accessSize,
    input  opTypesPkg::atomicOpT atomicOp,
    input  memTypesPkg::wordT storeValue,
    input  logic hit,
    input  memTypesPkg::wordT loadWord,
    input  memTypesPkg::lineT lineValue,
    output memTypesPkg::addrT lookupAddr,
    output opTypesPkg::accessSizeT heldAccessSize,
    output logic refillEnable,
    output memTypesPkg::lineT refillLine,
    output logic storeEnable,
    output memTypesPkg::wordT storeWord,
    output logic done,
    output memTypesPkg::wordT result,
    output memTypesPkg::lineAddrT memAddr,
    output logic memReadReq,
    output logic memWriteReq,
    output memTypesPkg::lineT memWriteValue,
    input  logic memReadGrant,
    input  logic memWriteGrant,
    input  memTypesPkg::lineT memReadValue,
    output memTypesPkg::wordT hostIoValue
);
    localparam memTypesPkg::addrT hostIoAddr = `LSU_HOST_IO_ADDR;

    opTypesPkg::controlStateT state;
    opTypesPkg::controlStateT nextState;
    memTypesPkg::addrT heldAddr;
    opTypesPkg::lsuCommandT heldCommand;
    opTypesPkg::atomicOpT heldAtomicOp;
    memTypesPkg::wordT heldValue;
    memTypesPkg::wordT oldWord;
    memTypesPkg::wordT aluResult;
    memTypesPkg::wordT writtenWord;
    logic hostIoWrite;

    function automatic memTypesPkg::wordT atomicAlu(
        opTypesPkg::atomicOpT op,
        memTypesPkg::wordT operand,
        memTypesPkg::wordT memValue
    );
        case (op)
            opTypesPkg::atomicAdd: return operand + memValue;
            opTypesPkg::atomicXor: return operand ^ memValue;
            opTypesPkg::atomicAnd: return operand & memValue;
            opTypesPkg::atomicOr: return operand | memValue;
            opTypesPkg::atomicMin: return ($signed(operand) < $signed(memValue)) ? operand : memValue;
            opTypesPkg::atomicMax: return ($signed(operand) > $signed(memValue)) ? operand : memValue;
            opTypesPkg::atomicMinu: return (operand < memValue) ? operand : memValue;
            opTypesPkg::atomicMaxu: return (operand > memValue) ? operand : memValue;
            default: return operand;
        endcase
    endfunction

    always_comb begin
        nextState = state;
        done = 1'b0;
        case (state)
            opTypesPkg::stateIdle: begin
                if (enable) begin
                    nextState = opTypesPkg::stateLookup;
                end
            end
            opTypesPkg::stateLookup: begin
                if (heldCommand == opTypesPkg::commandNone) begin
                    nextState = opTypesPkg::stateIdle;
                    done = 1'b1;
                end else if (!hit) begin
                    nextState = opTypesPkg::stateRefill;
                end else if (heldCommand == opTypesPkg::commandLoad) begin
                    nextState = opTypesPkg::stateIdle;
                    done = 1'b1;
                end else begin
                    nextState = opTypesPkg::stateStore;
                end
            end
            opTypesPkg::stateStore: begin
                nextState = opTypesPkg::stateWriteThrough;
            end
            opTypesPkg::stateWriteThrough: begin
                if (memWriteGrant) begin
                    nextState = opTypesPkg::stateIdle;
                    done = 1'b1;
                end
            end
            opTypesPkg::stateRefill: begin
                // Requester still holds the request, so it is retried
                if (memReadGrant) begin
                    nextState = opTypesPkg::stateIdle;
                end
            end
            default: begin
                nextState = opTypesPkg::stateIdle;
            end
        endcase
    end

    always_comb begin
        case (heldCommand)
            opTypesPkg::commandLoad: result = loadWord;
            opTypesPkg::commandAtomic: result = oldWord;
            default: result = '0;
        endcase
    end

    assign lookupAddr = (state == opTypesPkg::stateIdle) ? addr : heldAddr;
    assign refillEnable = (state == opTypesPkg::stateRefill) && memReadGrant;
    assign refillLine = memReadValue;
    assign storeEnable = (state == opTypesPkg::stateStore);
    assign aluResult = atomicAlu(heldAtomicOp, heldValue, oldWord);
    assign storeWord = (heldCommand == opTypesPkg::commandAtomic) ? aluResult : heldValue;

    assign memAddr = heldAddr[`LSU_ADDR_WIDTH-1:`LSU_OFFSET_WIDTH];
    assign memReadReq = (state == opTypesPkg::stateRefill);
    assign memWriteReq = (state == opTypesPkg::stateWriteThrough);
    assign memWriteValue = lineValue;

    // Host word as merged into the written line
    assign writtenWord = lineValue[`LSU_WORD_WIDTH * heldAddr[`LSU_OFFSET_WIDTH-1:2]
        +: `LSU_WORD_WIDTH];
    assign hostIoWrite = memWriteReq && memWriteGrant
        && (heldAddr[`LSU_ADDR_WIDTH-1:2] == hostIoAddr[`LSU_ADDR_WIDTH-1:2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= opTypesPkg::stateIdle;
            hostIoValue <= '0;
        end else begin
            state <= nextState;
            if (hostIoWrite) begin
                hostIoValue <= writtenWord;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == opTypesPkg::stateIdle) begin
            heldAddr <= addr;
            heldCommand <= command;
            heldAccessSize <= accessSize;
            heldAtomicOp <= atomicOp;
            heldValue <= storeValue;
        end
        if (state == opTypesPkg::stateLookup) begin
            oldWord <= loadWord;
        end
    end

    doneNeverIdle: assert property (@(posedge clk) disable iff (rst)
        done |-> (state != opTypesPkg::stateIdle));

    memReqExclusive: assert property (@(posedge clk) disable iff (rst)
        !(memReadReq && memWriteReq));

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
//**************************************************************************
// Load/store unit
// Direct-mapped write-through data cache with a line-wide memory port
//**************************************************************************

`default_nettype none

module loadStoreUnit (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  opTypesPkg::lsuCommandT command,
    input  memTypesPkg::addrT addr,
    input  opTypesPkg::accessSizeT accessSize,
    input  opTypesPkg::atomicOpT atomicOp,
    input  memTypesPkg::wordT storeValue,
    output logic done,
    output memTypesPkg::wordT result,
    output memTypesPkg::lineAddrT memAddr,
    output logic memReadReq,
    output logic memWriteReq,
    output memTypesPkg::lineT memWriteValue,
    input  logic memReadGrant,
    input  logic memWriteGrant,
    input  memTypesPkg::lineT memReadValue,
    output memTypesPkg::wordT hostIoValue
);
    memTypesPkg::addrT lookupAddr;
    opTypesPkg::accessSizeT heldAccessSize;
    logic refillEnable;
    memTypesPkg::lineT refillLine;
    logic storeEnable;
    memTypesPkg::wordT storeWord;
    logic hit;
    memTypesPkg::wordT loadWord;
    memTypesPkg::lineT lineValue;

    tagArray tagStore (
        .clk,
        .rst,
        .lookupAddr,
        .refillEnable,
        .hit
    );

    dataArray dataStore (
        .clk,
        .lookupAddr,
        .accessSize(heldAccessSize),
        .refillEnable,
        .refillLine,
        .storeEnable,
        .storeWord,
        .loadWord,
        .lineValue
    );

    loadStoreControl control (
        .clk, .rst, .enable, .command, .addr, .accessSize, .atomicOp, .storeValue,
        .hit, .loadWord, .lineValue,
        .lookupAddr, .heldAccessSize, .refillEnable, .refillLine,
        .storeEnable, .storeWord, .done, .result,
        .memAddr, .memReadReq, .memWriteReq, .memWriteValue,
        .memReadGrant, .memWriteGrant, .memReadValue,
        .hostIoValue
    );

endmodule

`default_nettype wire

// File: bench/backingMemory.sv
//**************************************************************************
// Backing memory model
// Line-wide memory behind the load/store unit, granting each read or
// write request after a random delay of 0 to 7 cycles
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

module backingMemory (
    input  logic clk,
    input  logic rst,
    input  memTypesPkg::lineAddrT memAddr,
    input  logic memReadReq,
    input  logic memWriteReq,
    input  memTypesPkg::lineT memWriteValue,
    output logic memReadGrant,
    output logic memWriteGrant,
    output memTypesPkg::lineT memReadValue
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int lineCount = 1 << (`LSU_ADDR_WIDTH - `LSU_OFFSET_WIDTH);

    memTypesPkg::lineT lines [lineCount];
    logic [31:0] lfsrState;
    int waitLeft;
    logic busy;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] takeBits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    function automatic memTypesPkg::lineT linePattern(memTypesPkg::lineAddrT lineAddr);
        memTypesPkg::lineT value;
        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            value[8*b +: 8] = 8'(lineAddr * (2 * b + 3) + (lineAddr >> b) + 8'h5b * b);
        end
        return value;
    endfunction

    initial begin
        lfsrState = 32'h74ff;
        busy = 1'b0;
        waitLeft = 0;
        memReadGrant = 1'b0;
        memWriteGrant = 1'b0;
        memReadValue = '0;
        for (int a = 0; a < lineCount; a++) begin
            lines[a] = linePattern(memTypesPkg::lineAddrT'(a));
        end
        forever begin
            @(posedge clk);
            #1;
            memReadGrant = 1'b0;
            memWriteGrant = 1'b0;
            if (!rst && !busy && (memReadReq || memWriteReq)) begin
                busy = 1'b1;
                waitLeft = int'(takeBits(3));
            end
            if (busy && waitLeft > 0) begin
                waitLeft--;
            end else if (busy) begin
                busy = 1'b0;
                if (memReadReq) begin
                    memReadValue = lines[memAddr];
                    memReadGrant = 1'b1;
                end else begin
                    lines[memAddr] = memWriteValue;
                    memWriteGrant = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/loadStoreUnitTb.sv
//**************************************************************************
// Load/store unit testbench
// Random loads, stores and atomics over 32 lines, checked against a
// byte-level reference model, with write-through and host I/O checks
//**************************************************************************

`default_nettype none

`include "lsu_consts.svh"

module loadStoreUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int opCount = 400;
    localparam int blockSize = 100;
    localparam int cyclesPerOp = 40;
    localparam int resetCycles = 10;
    localparam int cycleLimit = opCount * cyclesPerOp + 4 * resetCycles;
    localparam memTypesPkg::addrT regionBase = 16'hff00;
    localparam memTypesPkg::addrT hostIoAddr = `LSU_HOST_IO_ADDR;

    logic clk;
    logic rst;
    logic enable;
    opTypesPkg::lsuCommandT command;
    memTypesPkg::addrT addr;
    opTypesPkg::accessSizeT accessSize;
    opTypesPkg::atomicOpT atomicOp;
    memTypesPkg::wordT storeValue;
    logic done;
    memTypesPkg::wordT result;
    memTypesPkg::lineAddrT memAddr;
    logic memReadReq;
    logic memWriteReq;
    memTypesPkg::lineT memWriteValue;
    logic memReadGrant;
    logic memWriteGrant;
    memTypesPkg::lineT memReadValue;
    memTypesPkg::wordT hostIoValue;

    // Reference model of the 256-byte region at regionBase
    logic [7:0] model [256];
    memTypesPkg::wordT modelHostIo;
    logic [31:0] lfsrState;
    int cycleCount;
    int checkCount;
    int errorCount;
    int loadCount;
    int storeCount;
    int atomicCount;
    logic stuck;
    logic lastWasStore;
    memTypesPkg::addrT lastStoreAddr;

    loadStoreUnit UUT (.*);

    backingMemory backing (
        .clk,
        .rst,
        .memAddr,
        .memReadReq,
        .memWriteReq,
        .memWriteValue,
        .memReadGrant,
        .memWriteGrant,
        .memReadValue
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run exceeded %0d cycles", cycleLimit);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] takeBits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    // Same initial contents as the backing memory
    function automatic memTypesPkg::lineT linePattern(memTypesPkg::lineAddrT lineAddr);
        memTypesPkg::lineT value;
        for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
            value[8*b +: 8] = 8'(lineAddr * (2 * b + 3) + (lineAddr >> b) + 8'h5b * b);
        end
        return value;
    endfunction

    function automatic int sizeBytes(opTypesPkg::accessSizeT size);
        case (size)
            opTypesPkg::sizeWord: return 4;
            opTypesPkg::sizeHalf, opTypesPkg::sizeHalfUnsigned: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic memTypesPkg::wordT applyAtomic(
        opTypesPkg::atomicOpT op,
        memTypesPkg::wordT operand,
        memTypesPkg::wordT old
    );
        logic signedLess;
        logic unsignedLess;
        signedLess = $signed(operand) < $signed(old);
        unsignedLess = operand < old;
        case (op)
            opTypesPkg::atomicSwap: return operand;
            opTypesPkg::atomicAdd: return operand + old;
            opTypesPkg::atomicXor: return operand ^ old;
            opTypesPkg::atomicAnd: return operand & old;
            opTypesPkg::atomicOr: return operand | old;
            opTypesPkg::atomicMin: return signedLess ? operand : old;
            opTypesPkg::atomicMax: return signedLess ? old : operand;
            opTypesPkg::atomicMinu: return unsignedLess ? operand : old;
            default: return unsignedLess ? old : operand;
        endcase
    endfunction

    task automatic reportMismatch(string name, logic [63:0] expected, logic [63:0] actual);
        errorCount++;
        $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic checkResetState();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (4) begin
            @(negedge clk);
            checkCount += 4;
            if (done !== 1'b0) reportMismatch("done", 64'd0, 64'(done));
            if (memReadReq !== 1'b0) reportMismatch("memReadReq", 64'd0, 64'(memReadReq));
            if (memWriteReq !== 1'b0) reportMismatch("memWriteReq", 64'd0, 64'(memWriteReq));
            if (hostIoValue !== '0) reportMismatch("hostIoValue", 64'd0, 64'(hostIoValue));
        end
        @(posedge clk);
        #1;
        $display("Test 1 reset state: %0d errors", errorCount - errorsBefore);
    endtask

    // Hold the request until done, then release it after the edge
    task automatic runOperation(
        input opTypesPkg::lsuCommandT cmd,
        input memTypesPkg::addrT opAddr,
        input opTypesPkg::accessSizeT size,
        input opTypesPkg::atomicOpT op,
        input memTypesPkg::wordT value,
        output memTypesPkg::wordT got,
        output logic finished
    );
        int waited;
        waited = 0;
        finished = 1'b0;
        got = '0;
        enable = 1'b1;
        command = cmd;
        addr = opAddr;
        accessSize = size;
        atomicOp = op;
        storeValue = value;
        while (!finished && waited < cyclesPerOp) begin
            @(negedge clk);
            if (done) begin
                finished = 1'b1;
                got = result;
            end
            waited++;
        end
        @(posedge clk);
        #1;
        enable = 1'b0;
        command = opTypesPkg::commandNone;
    endtask

    task automatic randomOperation(int opIndex);
        opTypesPkg::lsuCommandT cmd;
        opTypesPkg::accessSizeT size;
        opTypesPkg::atomicOpT op;
        memTypesPkg::addrT opAddr;
        memTypesPkg::wordT value;
        memTypesPkg::wordT oldWord;
        memTypesPkg::wordT newWord;
        memTypesPkg::wordT expected;
        memTypesPkg::wordT got;
        memTypesPkg::lineT modelLine;
        memTypesPkg::lineT memLine;
        logic [7:0] base;
        logic [2:0] offset;
        logic followUp;
        logic hostBias;
        logic finished;

        followUp = lastWasStore && takeBits(1) == 32'd1;
        cmd = opTypesPkg::lsuCommandT'(2'(takeBits(2)));
        size = opTypesPkg::accessSizeT'(3'(takeBits(3) % 5));
        op = opTypesPkg::atomicOpT'(4'(takeBits(4) % 9));
        value = takeBits(32);
        opAddr = {regionBase[15:8], 5'(takeBits(5)), 3'b000};
        offset = 3'(takeBits(3));
        hostBias = takeBits(3) == 32'd0;
        if (cmd == opTypesPkg::commandNone) cmd = opTypesPkg::commandLoad;
        if (cmd == opTypesPkg::commandAtomic) size = opTypesPkg::sizeWord;
        offset = offset & 3'(~(sizeBytes(size) - 1));
        opAddr[2:0] = offset;
        if (hostBias && cmd != opTypesPkg::commandLoad) begin
            opAddr = hostIoAddr | {14'd0, offset[1:0]};
        end
        // Read back the whole word of the last store
        if (followUp) begin
            cmd = opTypesPkg::commandLoad;
            size = opTypesPkg::sizeWord;
            opAddr = {lastStoreAddr[15:2], 2'b00};
        end

        base = opAddr[7:0];
        oldWord = {model[base + 8'd3], model[base + 8'd2], model[base + 8'd1], model[base]};
        expected = '0;
        case (cmd)
            opTypesPkg::commandLoad: begin
                loadCount++;
                case (size)
                    opTypesPkg::sizeWord: expected = oldWord;
                    opTypesPkg::sizeHalf: expected = {{16{oldWord[15]}}, oldWord[15:0]};
                    opTypesPkg::sizeHalfUnsigned: expected = {16'h0000, oldWord[15:0]};
                    opTypesPkg::sizeByte: expected = {{24{oldWord[7]}}, oldWord[7:0]};
                    default: expected = {24'h000000, oldWord[7:0]};
                endcase
            end
            opTypesPkg::commandStore: begin
                storeCount++;
                for (int i = 0; i < sizeBytes(size); i++) begin
                    model[base + 8'(i)] = value[8*i +: 8];
                end
            end
            default: begin
                atomicCount++;
                newWord = applyAtomic(op, value, oldWord);
                for (int i = 0; i < 4; i++) begin
                    model[base + 8'(i)] = newWord[8*i +: 8];
                end
                expected = oldWord;
            end
        endcase
        if (cmd != opTypesPkg::commandLoad && opAddr[15:2] == hostIoAddr[15:2]) begin
            modelHostIo = {model[8'hff], model[8'hfe], model[8'hfd], model[8'hfc]};
        end
        lastWasStore = cmd == opTypesPkg::commandStore;
        lastStoreAddr = opAddr;

        runOperation(cmd, opAddr, size, op, value, got, finished);
        if (!finished) begin
            $display("Operation %0d at address %h did not finish within %0d cycles",
                opIndex, opAddr, cyclesPerOp);
            errorCount++;
            stuck = 1'b1;
        end else begin
            checkCount += 2;
            if (got !== expected) reportMismatch("result", 64'(expected), 64'(got));
            if (hostIoValue !== modelHostIo) begin
                reportMismatch("hostIoValue", 64'(modelHostIo), 64'(hostIoValue));
            end
            if (cmd != opTypesPkg::commandLoad) begin
                for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
                    modelLine[8*b +: 8] = model[{base[7:3], 3'(b)}];
                end
                memLine = backing.lines[opAddr[15:3]];
                checkCount++;
                if (memLine !== modelLine) reportMismatch("memory line", modelLine, memLine);
            end
        end
    endtask

    initial begin
        memTypesPkg::lineT initLine;
        int errorsBefore;
        lfsrState = 32'h74ff;
        checkCount = 0;
        errorCount = 0;
        stuck = 1'b0;
        lastWasStore = 1'b0;
        lastStoreAddr = '0;
        modelHostIo = '0;
        rst = 1'b1;
        enable = 1'b0;
        command = opTypesPkg::commandNone;
        addr = '0;
        accessSize = opTypesPkg::sizeWord;
        atomicOp = opTypesPkg::atomicSwap;
        storeValue = '0;
        for (int i = 0; i < 256; i++) begin
            initLine = linePattern({regionBase[15:8], 5'(i >> 3)});
            model[i] = initLine[8*(i % 8) +: 8];
        end

        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        checkResetState();

        for (int block = 0; block < opCount / blockSize; block++) begin
            errorsBefore = errorCount;
            loadCount = 0;
            storeCount = 0;
            atomicCount = 0;
            for (int i = 0; i < blockSize && !stuck; i++) begin
                randomOperation(block * blockSize + i);
            end
            $display("Test %0d random operations: %0d loads, %0d stores, %0d atomics, %0d errors",
                block + 2, loadCount, storeCount, atomicCount, errorCount - errorsBefore);
        end

        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/memTypesPkg.sv
src/opTypesPkg.sv
src/tagArray.sv
src/dataArray.sv
src/loadStoreControl.sv
src/loadStoreUnit.sv
bench/backingMemory.sv
bench/loadStoreUnitTb.sv

// File: Makefile
# Verilator simulation of the load/store unit testbench

VERILATOR ?= verilator
TOP ?= loadStoreUnitTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
